// ==== logic/recovery_pkg.sv ====
// Command and error codes, CSR word indices, CSR lengths, constants and port structs
package recovery_pkg;

  // Indirect FIFO geometry
  localparam int unsigned FifoDepth = 16;
  localparam int unsigned FifoIdxW = 4;
  localparam logic [15:0] MaxXferBytes = 16'd64;

  // Codes from here upward need recovery mode
  localparam logic [7:0] FirstRecoveryOnlyCmd = 8'd40;

  typedef enum logic [7:0] {
    CMD_PROT_CAP             = 8'd34,
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } recovery_cmd_e;

  typedef enum logic [7:0] {
    ERR_OK        = 8'd0,
    ERR_READ_ONLY = 8'd1,
    ERR_PARAMETER = 8'd2,
    ERR_LENGTH    = 8'd3,
    ERR_CRC       = 8'd4
  } proto_err_e;

  // One entry per 32-bit CSR word
  typedef enum logic [3:0] {
    CSR_PROT_CAP_0    = 4'd0,
    CSR_PROT_CAP_1    = 4'd1,
    CSR_DEV_STATUS    = 4'd2,
    CSR_DEV_RESET     = 4'd3,
    CSR_REC_CTRL      = 4'd4,
    CSR_FIFO_CTRL     = 4'd5,
    CSR_FIFO_STATUS_0 = 4'd6,
    CSR_FIFO_STATUS_1 = 4'd7,
    CSR_FIFO_STATUS_2 = 4'd8,
    CSR_FIFO_STATUS_3 = 4'd9
  } csr_idx_e;

  // CSR lengths in bytes
  localparam logic [15:0] ProtCapLen = 16'd8;
  localparam logic [15:0] DeviceStatusLen = 16'd4;
  localparam logic [15:0] DeviceResetLen = 16'd3;
  localparam logic [15:0] RecoveryCtrlLen = 16'd3;
  localparam logic [15:0] FifoCtrlLen = 16'd2;
  localparam logic [15:0] FifoStatusLen = 16'd16;

  // "OCP " and "RECV", first character in the low byte
  localparam logic [31:0] MagicWord0 = 32'h2050_434F;
  localparam logic [31:0] MagicWord1 = 32'h5643_4552;

  localparam logic [7:0] ImageActivateCode = 8'h0F;
  localparam logic [7:0] FifoResetCode = 8'h01;

  typedef struct packed {
    recovery_cmd_e cmd;
    logic [15:0]   len;
    logic          is_rd;
    logic          crc_err;
  } cmd_req_t;

  typedef struct packed {
    logic        valid;
    csr_idx_e    idx;
    logic [31:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic                full;
    logic                empty;
    logic [FifoIdxW-1:0] wr_idx;
    logic [FifoIdxW-1:0] rd_idx;
  } fifo_status_t;

  typedef struct packed {
    logic       valid;
    proto_err_e code;
  } proto_upd_t;

endpackage

// ==== logic/recovery_cmd_fsm.sv ====
// Command FSM with word and byte counters, write-data router and response serializer
`timescale 1ns/100ps

module recovery_cmd_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       recovery_mode_i,
  input  logic                       cmd_valid_i,
  input  recovery_pkg::cmd_req_t     cmd_i,
  output logic                       cmd_ready_o,
  output logic                       cmd_done_o,
  input  logic                       rx_valid_i,
  input  logic [31:0]                rx_data_i,
  output logic                       rx_ready_o,
  output logic                       rx_clr_o,
  output logic                       res_valid_o,
  output logic [15:0]                res_len_o,
  input  logic                       res_ready_i,
  output logic                       res_dvalid_o,
  output logic [7:0]                 res_data_o,
  output logic                       res_dlast_o,
  input  logic                       res_dready_i,
  input  recovery_pkg::fifo_status_t fifo_status_i,
  input  logic [31:0]                csr_rdata_i,
  output recovery_pkg::csr_idx_e     csr_rd_idx_o,
  output recovery_pkg::csr_wr_t      csr_wr_o,
  output recovery_pkg::proto_upd_t   proto_upd_o,
  output logic                       fifo_push_o,
  output logic [31:0]                fifo_wdata_o
);
  import recovery_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    CsrWrite,
    FifoWrite,
    RespHdr,
    RespData,
    Error,
    Done
  } state_e;

  state_e      state_q, state_d;
  csr_idx_e    csr_idx_q;
  proto_err_e  err_q;
  logic [15:0] len_q;
  logic [13:0] word_cnt_q;
  logic [15:0] byte_cnt_q;
  logic [1:0]  lane_q;

  logic        cmd_xfer, rx_xfer, byte_xfer;
  logic        cmd_known, cmd_read_only;
  csr_idx_e    first_idx;
  logic [15:0] csr_len;
  logic [13:0] num_words;
  proto_err_e  acc_err;
  logic [2:0]  tail_bytes, new_bytes;
  logic [31:0] wr_merged;

  // First CSR word and length of the addressed register
  always_comb begin
    cmd_known     = 1'b1;
    cmd_read_only = 1'b0;
    first_idx     = CSR_PROT_CAP_0;
    csr_len       = '0;
    case (cmd_i.cmd)
      CMD_PROT_CAP: begin
        csr_len       = ProtCapLen;
        cmd_read_only = 1'b1;
      end
      CMD_DEVICE_STATUS: begin
        first_idx     = CSR_DEV_STATUS;
        csr_len       = DeviceStatusLen;
        cmd_read_only = 1'b1;
      end
      CMD_DEVICE_RESET: begin
        first_idx = CSR_DEV_RESET;
        csr_len   = DeviceResetLen;
      end
      CMD_RECOVERY_CTRL: begin
        first_idx = CSR_REC_CTRL;
        csr_len   = RecoveryCtrlLen;
      end
      CMD_INDIRECT_FIFO_CTRL: begin
        first_idx = CSR_FIFO_CTRL;
        csr_len   = FifoCtrlLen;
      end
      CMD_INDIRECT_FIFO_STATUS: begin
        first_idx     = CSR_FIFO_STATUS_0;
        csr_len       = FifoStatusLen;
        cmd_read_only = 1'b1;
      end
      CMD_INDIRECT_FIFO_DATA: csr_len = MaxXferBytes;
      default: cmd_known = 1'b0;
    endcase
  end

  // Classification, first failing check wins
  always_comb begin
    acc_err = ERR_OK;
    if (cmd_i.crc_err) begin
      acc_err = ERR_CRC;
    end else if (!cmd_known || (cmd_i.cmd >= FirstRecoveryOnlyCmd && !recovery_mode_i) ||
                 (cmd_i.cmd == CMD_INDIRECT_FIFO_DATA && cmd_i.is_rd)) begin
      acc_err = ERR_PARAMETER;
    end else if (!cmd_i.is_rd && cmd_read_only) begin
      acc_err = ERR_READ_ONLY;
    end else if (!cmd_i.is_rd && cmd_i.len > csr_len) begin
      acc_err = ERR_LENGTH;
    end
  end

  // Length in words, rounded up
  assign num_words = cmd_i.len[15:2] + {13'd0, |cmd_i.len[1:0]};

  assign cmd_ready_o  = (state_q == Idle);
  assign cmd_xfer     = cmd_valid_i && cmd_ready_o;
  assign rx_ready_o   = (state_q == CsrWrite) || (state_q == FifoWrite && !fifo_status_i.full);
  assign rx_xfer      = rx_valid_i && rx_ready_o;
  assign res_valid_o  = (state_q == RespHdr);
  assign res_dvalid_o = (state_q == RespData);
  assign byte_xfer    = res_dvalid_o && res_dready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (cmd_xfer) begin
          if (acc_err != ERR_OK) state_d = Error;
          else if (cmd_i.is_rd) state_d = RespHdr;
          else if (num_words == '0) state_d = Done;
          else if (cmd_i.cmd == CMD_INDIRECT_FIFO_DATA) state_d = FifoWrite;
          else state_d = CsrWrite;
        end
      end
      CsrWrite, FifoWrite: if (rx_xfer && word_cnt_q == 14'd1) state_d = Done;
      RespHdr: if (res_ready_i) state_d = RespData;
      RespData: if (byte_xfer && byte_cnt_q == 16'd1) state_d = Done;
      Error: state_d = Done;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      csr_idx_q  <= CSR_PROT_CAP_0;
      err_q      <= ERR_OK;
      len_q      <= '0;
      word_cnt_q <= '0;
      byte_cnt_q <= '0;
      lane_q     <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_xfer) begin
        csr_idx_q  <= first_idx;
        err_q      <= acc_err;
        len_q      <= cmd_i.is_rd ? csr_len : cmd_i.len;
        word_cnt_q <= num_words;
        byte_cnt_q <= csr_len;
        lane_q     <= '0;
      end
      if (rx_xfer) begin
        word_cnt_q <= word_cnt_q - 14'd1;
        csr_idx_q  <= csr_idx_e'(csr_idx_q + 4'd1);
      end
      if (byte_xfer) begin
        byte_cnt_q <= byte_cnt_q - 16'd1;
        lane_q     <= lane_q + 2'd1;
        if (lane_q == 2'd3) csr_idx_q <= csr_idx_e'(csr_idx_q + 4'd1);
      end
    end
  end

  // Partial last word keeps the old upper bytes of the CSR
  always_comb begin
    tail_bytes = (len_q[1:0] == 2'd0) ? 3'd4 : {1'b0, len_q[1:0]};
    new_bytes  = (word_cnt_q == 14'd1) ? tail_bytes : 3'd4;
    for (int b = 0; b < 4; b++) begin
      wr_merged[8*b +: 8] = (3'(b) < new_bytes) ? rx_data_i[8*b +: 8] : csr_rdata_i[8*b +: 8];
    end
  end

  assign csr_rd_idx_o   = csr_idx_q;
  assign csr_wr_o.valid = rx_xfer && (state_q == CsrWrite);
  assign csr_wr_o.idx   = csr_idx_q;
  assign csr_wr_o.data  = wr_merged;
  assign fifo_push_o    = rx_xfer && (state_q == FifoWrite);
  assign fifo_wdata_o   = rx_data_i;

  // Response header and byte stream, low byte first
  assign res_len_o   = len_q;
  assign res_data_o  = csr_rdata_i[8*lane_q +: 8];
  assign res_dlast_o = res_dvalid_o && (byte_cnt_q == 16'd1);

  assign rx_clr_o          = (state_q == Error);
  assign cmd_done_o        = (state_q == Done);
  assign proto_upd_o.valid = (state_q == Done);
  assign proto_upd_o.code  = err_q;

endmodule

// ==== logic/recovery_csr_bank.sv ====
// Recovery CSR storage, read-word mux, protocol status byte, FIFO reset pulse and activation
`timescale 1ns/100ps

module recovery_csr_bank (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  recovery_pkg::csr_wr_t      csr_wr_i,
  input  recovery_pkg::csr_idx_e     csr_rd_idx_i,
  input  recovery_pkg::proto_upd_t   proto_upd_i,
  input  recovery_pkg::fifo_status_t fifo_status_i,
  output logic [31:0]                csr_rdata_o,
  output logic                       fifo_clr_o,
  output logic                       image_activated_o
);
  import recovery_pkg::*;

  // DEVICE_RESET and RECOVERY_CTRL hold three bytes
  logic [23:0] dev_reset_q;
  logic [23:0] rec_ctrl_q;
  // Byte 0 is CMS, byte 1 is the reset request
  logic [15:0] fifo_ctrl_q;
  logic [7:0]  proto_q;

  logic        fifo_ctrl_wr;

  assign fifo_ctrl_wr = csr_wr_i.valid && (csr_wr_i.idx == CSR_FIFO_CTRL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_reset_q <= '0;
      rec_ctrl_q  <= '0;
    end else if (csr_wr_i.valid) begin
      case (csr_wr_i.idx)
        CSR_DEV_RESET: dev_reset_q <= csr_wr_i.data[23:0];
        CSR_REC_CTRL:  rec_ctrl_q <= csr_wr_i.data[23:0];
        default: ;
      endcase
    end
  end

  // Reset byte clears itself on the edge after it was set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fifo_ctrl_q <= '0;
    end else if (fifo_ctrl_wr) begin
      fifo_ctrl_q <= csr_wr_i.data[15:0];
    end else if (|fifo_ctrl_q[15:8]) begin
      fifo_ctrl_q[15:8] <= '0;
    end
  end

  // Status of the last finished command
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      proto_q <= '0;
    end else if (proto_upd_i.valid) begin
      proto_q <= proto_upd_i.code;
    end
  end

  assign fifo_clr_o        = (fifo_ctrl_q[15:8] == FifoResetCode);
  assign image_activated_o = (rec_ctrl_q[23:16] == ImageActivateCode);

  always_comb begin
    case (csr_rd_idx_i)
      CSR_PROT_CAP_0:    csr_rdata_o = MagicWord0;
      CSR_PROT_CAP_1:    csr_rdata_o = MagicWord1;
      CSR_DEV_STATUS:    csr_rdata_o = {16'd0, proto_q, 8'd0};
      CSR_DEV_RESET:     csr_rdata_o = {8'd0, dev_reset_q};
      CSR_REC_CTRL:      csr_rdata_o = {8'd0, rec_ctrl_q};
      CSR_FIFO_CTRL:     csr_rdata_o = {16'd0, fifo_ctrl_q};
      CSR_FIFO_STATUS_0: csr_rdata_o = {30'd0, fifo_status_i.full, fifo_status_i.empty};
      CSR_FIFO_STATUS_1: csr_rdata_o = 32'(fifo_status_i.wr_idx);
      CSR_FIFO_STATUS_2: csr_rdata_o = 32'(fifo_status_i.rd_idx);
      CSR_FIFO_STATUS_3: csr_rdata_o = 32'(FifoDepth);
      default:           csr_rdata_o = '0;
    endcase
  end

endmodule

// ==== logic/recovery_indirect_fifo.sv ====
// Indirect FIFO storage with wrapping indices, clear, full and empty flags and payload flag
`timescale 1ns/100ps

module recovery_indirect_fifo (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  logic [31:0]                wdata_i,
  input  logic                       clr_i,
  input  logic                       image_activated_i,
  input  logic                       rreq_i,
  output logic                       rvalid_o,
  output logic [31:0]                rdata_o,
  output recovery_pkg::fifo_status_t status_o,
  output logic                       payload_available_o
);
  import recovery_pkg::*;

  logic [31:0]         mem_q [FifoDepth];
  logic [FifoIdxW-1:0] wr_idx_q, rd_idx_q;
  logic [FifoIdxW:0]   count_q;
  logic [31:0]         rdata_q;
  logic                rvalid_q;
  logic                payload_q;

  logic full, empty, do_push, do_pop;

  function automatic logic [FifoIdxW-1:0] next_idx(input logic [FifoIdxW-1:0] idx);
    next_idx = (idx == FifoIdxW'(FifoDepth - 1)) ? '0 : idx + 1'b1;
  endfunction

  assign full    = (count_q == (FifoIdxW + 1)'(FifoDepth));
  assign empty   = (count_q == '0);
  assign do_push = push_i && !full;
  assign do_pop  = rreq_i && !empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_idx_q <= next_idx(wr_idx_q);
      if (do_pop) rd_idx_q <= next_idx(rd_idx_q);
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  // Storage and read data
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_idx_q] <= wdata_i;
    if (do_pop) rdata_q <= mem_q[rd_idx_q];
  end

  // Read answer one cycle after the request, dropped when empty
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rvalid_q <= 1'b0;
    else rvalid_q <= do_pop;
  end

  // Full image, or activated with data left
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) payload_q <= 1'b0;
    else if (full || (image_activated_i && !empty)) payload_q <= 1'b1;
    else if (empty) payload_q <= 1'b0;
  end

  assign rvalid_o            = rvalid_q;
  assign rdata_o             = rdata_q;
  assign payload_available_o = payload_q;

  assign status_o.full   = full;
  assign status_o.empty  = empty;
  assign status_o.wr_idx = wr_idx_q;
  assign status_o.rd_idx = rd_idx_q;

endmodule

// ==== logic/recovery_executor.sv ====
// Recovery executor top level joining command FSM, CSR bank and indirect FIFO
`timescale 1ns/100ps

module recovery_executor (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   recovery_mode_i,
  input  logic                   cmd_valid_i,
  input  recovery_pkg::cmd_req_t cmd_i,
  output logic                   cmd_ready_o,
  output logic                   cmd_done_o,
  input  logic                   rx_valid_i,
  input  logic [31:0]            rx_data_i,
  output logic                   rx_ready_o,
  output logic                   rx_clr_o,
  output logic                   res_valid_o,
  output logic [15:0]            res_len_o,
  input  logic                   res_ready_i,
  output logic                   res_dvalid_o,
  output logic [7:0]             res_data_o,
  output logic                   res_dlast_o,
  input  logic                   res_dready_i,
  input  logic                   ifd_rreq_i,
  output logic                   ifd_rvalid_o,
  output logic [31:0]            ifd_rdata_o,
  output logic                   payload_available_o
);
  import recovery_pkg::*;

  csr_wr_t      csr_wr;
  csr_idx_e     csr_rd_idx;
  logic [31:0]  csr_rdata;
  proto_upd_t   proto_upd;
  fifo_status_t fifo_status;
  logic         fifo_push;
  logic [31:0]  fifo_wdata;
  logic         fifo_clr;
  logic         image_activated;

  recovery_cmd_fsm u_cmd_fsm (
    .clk_i,
    .rst_ni,
    .recovery_mode_i,
    .cmd_valid_i,
    .cmd_i,
    .cmd_ready_o,
    .cmd_done_o,
    .rx_valid_i,
    .rx_data_i,
    .rx_ready_o,
    .rx_clr_o,
    .res_valid_o,
    .res_len_o,
    .res_ready_i,
    .res_dvalid_o,
    .res_data_o,
    .res_dlast_o,
    .res_dready_i,
    .fifo_status_i (fifo_status),
    .csr_rdata_i   (csr_rdata),
    .csr_rd_idx_o  (csr_rd_idx),
    .csr_wr_o      (csr_wr),
    .proto_upd_o   (proto_upd),
    .fifo_push_o   (fifo_push),
    .fifo_wdata_o  (fifo_wdata)
  );

  recovery_csr_bank u_csr_bank (
    .clk_i,
    .rst_ni,
    .csr_wr_i          (csr_wr),
    .csr_rd_idx_i      (csr_rd_idx),
    .proto_upd_i       (proto_upd),
    .fifo_status_i     (fifo_status),
    .csr_rdata_o       (csr_rdata),
    .fifo_clr_o        (fifo_clr),
    .image_activated_o (image_activated)
  );

  recovery_indirect_fifo u_indirect_fifo (
    .clk_i,
    .rst_ni,
    .push_i              (fifo_push),
    .wdata_i             (fifo_wdata),
    .clr_i               (fifo_clr),
    .image_activated_i   (image_activated),
    .rreq_i              (ifd_rreq_i),
    .rvalid_o            (ifd_rvalid_o),
    .rdata_o             (ifd_rdata_o),
    .status_o            (fifo_status),
    .payload_available_o (payload_available_o)
  );

endmodule

// ==== dv/recovery_tb.sv ====
// Testbench for the recovery executor with xorshift stimulus, CSR and FIFO models and checks
`timescale 1ns/100ps

module recovery_tb;
  import recovery_pkg::*;

  localparam int ClkPeriod = 10;
  localparam int MaxCmdCycles = 200;
  localparam int NumProtCap = 2;
  localparam int NumCsrWrites = 24;
  localparam int NumErrCases = 6;
  localparam int NumFifoRounds = 8;
  // Upper bound on commands issued over all tests, FIFO reads folded into the margin
  localparam int CmdBudget = NumProtCap + 2 * NumCsrWrites + 3 * NumErrCases +
                             3 * NumFifoRounds + 20;
  localparam int WatchdogNs = (CmdBudget * MaxCmdCycles + 20) * ClkPeriod;
  // Capability magic, first character in the low byte of the stream
  localparam logic [63:0] MagicText = "OCP RECV";

  logic        clk_i;
  logic        rst_ni;
  logic        recovery_mode_i;
  logic        cmd_valid_i;
  cmd_req_t    cmd_i;
  logic        cmd_ready_o;
  logic        cmd_done_o;
  logic        rx_valid_i;
  logic [31:0] rx_data_i;
  logic        rx_ready_o;
  logic        rx_clr_o;
  logic        res_valid_o;
  logic [15:0] res_len_o;
  logic        res_ready_i;
  logic        res_dvalid_o;
  logic [7:0]  res_data_o;
  logic        res_dlast_o;
  logic        res_dready_i;
  logic        ifd_rreq_i;
  logic        ifd_rvalid_o;
  logic [31:0] ifd_rdata_o;
  logic        payload_available_o;

  logic [31:0] rng;
  int          err_cnt;
  int          errs_at_test;
  int          tests_run;
  int          tests_failed;

  // Models of the RX source, the CSRs and the indirect FIFO
  logic [31:0] rx_q[$];
  logic [31:0] fifo_q[$];
  int          wr_m;
  int          rd_m;
  logic [7:0]  dev_reset_m [3];
  logic [7:0]  rec_ctrl_m [3];
  logic [7:0]  fifo_cms_m;
  logic [7:0]  proto_m;

  // What the last command produced
  logic [7:0]  got_q[$];
  bit          last_q[$];
  bit          done_seen;
  bit          clr_seen;
  int          hdr_cnt;
  logic [15:0] hdr_len;

  recovery_executor dut0 (.*);

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before all tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic bit coin();
    logic [31:0] r;
    r = rand32();
    return r[7];
  endfunction

  // Register length in bytes, zero for an unsupported code
  function automatic int csr_length(input logic [7:0] cmd);
    case (cmd)
      8'd34: return 8;
      8'd36: return 4;
      8'd37: return 3;
      8'd38: return 3;
      8'd45: return 2;
      8'd46: return 16;
      8'd47: return 64;
      default: return 0;
    endcase
  endfunction

  function automatic logic [7:0] expect_code(input logic [7:0] cmd, input int len,
                                             input bit is_rd, input bit crc, input logic mode);
    int limit;
    limit = csr_length(cmd);
    if (crc) return 8'd4;
    if (limit == 0 || (cmd >= 8'd40 && !mode) || (cmd == 8'd47 && is_rd)) return 8'd2;
    if (!is_rd && (cmd == 8'd34 || cmd == 8'd36 || cmd == 8'd46)) return 8'd1;
    if (!is_rd && len > limit) return 8'd3;
    return 8'd0;
  endfunction

  function automatic logic [7:0] exp_byte(input logic [7:0] cmd, input int i);
    logic [31:0] w;
    w = '0;
    case (cmd)
      8'd34: return MagicText[8 * (7 - i) +: 8];
      8'd36: return (i == 1) ? proto_m : 8'd0;
      8'd37: return dev_reset_m[i];
      8'd38: return rec_ctrl_m[i];
      8'd45: return (i == 0) ? fifo_cms_m : 8'd0;
      default: begin
        case (i / 4)
          0: w = {30'd0, fifo_q.size() == FifoDepth, fifo_q.size() == 0};
          1: w = 32'(wr_m);
          2: w = 32'(rd_m);
          default: w = 32'(FifoDepth);
        endcase
        return w[8 * (i % 4) +: 8];
      end
    endcase
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %s got 0x%0h expected 0x%0h at %0t", sig, got, exp, $time);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_cnt > errs_at_test) begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, err_cnt - errs_at_test);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    errs_at_test = err_cnt;
  endtask

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic send_cmd(input logic [7:0] cmd, input int len, input bit is_rd, input bit crc);
    cmd_i.cmd     = recovery_cmd_e'(cmd);
    cmd_i.len     = 16'(len);
    cmd_i.is_rd   = is_rd;
    cmd_i.crc_err = crc;
    cmd_valid_i   = 1'b1;
    @(negedge clk_i);
    while (!cmd_ready_o) @(negedge clk_i);
    tick();
    cmd_valid_i = 1'b0;
  endtask

  // Serves RX words and takes the response with random stalls until cmd_done_o
  task automatic wait_cmd(input bit to_fifo);
    int cyc;
    bit rx_pop;
    bit clr_now;
    done_seen = 1'b0;
    clr_seen  = 1'b0;
    hdr_cnt   = 0;
    got_q.delete();
    last_q.delete();
    cyc = 0;
    while (!done_seen && cyc < MaxCmdCycles) begin
      rx_valid_i   = coin() && (rx_q.size() > 0);
      rx_data_i    = (rx_q.size() > 0) ? rx_q[0] : '0;
      res_ready_i  = coin();
      res_dready_i = coin();
      @(negedge clk_i);
      rx_pop  = rx_valid_i && rx_ready_o;
      clr_now = rx_clr_o;
      if (cmd_done_o) done_seen = 1'b1;
      if (rx_clr_o) clr_seen = 1'b1;
      if (res_valid_o && res_ready_i) begin
        hdr_cnt++;
        hdr_len = res_len_o;
      end
      if (res_dvalid_o && res_dready_i) begin
        got_q.push_back(res_data_o);
        last_q.push_back(res_dlast_o);
      end
      tick();
      if (rx_pop) begin
        if (to_fifo) begin
          fifo_q.push_back(rx_q[0]);
          wr_m = (wr_m + 1) % FifoDepth;
        end
        void'(rx_q.pop_front());
      end
      if (clr_now) rx_q.delete();
      cyc++;
    end
    rx_valid_i   = 1'b0;
    res_ready_i  = 1'b0;
    res_dready_i = 1'b0;
    if (!done_seen) report_error("command did not finish, cmd_done_o never came");
  endtask

  task automatic run_cmd(input logic [7:0] cmd, input int len, input bit is_rd, input bit crc);
    logic [7:0]  code;
    logic [7:0]  b;
    int          exp_len;
    logic [7:0]  exp_q[$];
    logic [31:0] words[$];
    bit          to_fifo;
    code    = expect_code(cmd, len, is_rd, crc, recovery_mode_i);
    to_fifo = (cmd == 8'd47) && !is_rd && (code == 8'd0);
    exp_len = csr_length(cmd);
    if (is_rd && code == 8'd0) begin
      for (int i = 0; i < exp_len; i++) exp_q.push_back(exp_byte(cmd, i));
    end
    words = rx_q;
    send_cmd(cmd, len, is_rd, crc);
    wait_cmd(to_fifo);
    if (done_seen) begin
      if (code != 8'd0 && !clr_seen) report_error("rx_clr_o did not pulse for a rejected command");
      if (code == 8'd0 && clr_seen) report_error("rx_clr_o pulsed for an accepted command");
      if (is_rd && code == 8'd0) begin
        if (hdr_cnt != 1) report_error("response header was not seen exactly once");
        else if (hdr_len !== 16'(exp_len)) report_mismatch("res_len_o", 32'(hdr_len), exp_len);
        if (got_q.size() != exp_len) begin
          report_error("response byte count differs from the register length");
        end else begin
          for (int i = 0; i < exp_len; i++) begin
            if (got_q[i] !== exp_q[i]) report_mismatch("res_data_o", 32'(got_q[i]), 32'(exp_q[i]));
            if (last_q[i] != (i == exp_len - 1)) begin
              report_mismatch("res_dlast_o", 32'(last_q[i]), 32'(i == exp_len - 1));
            end
          end
        end
      end else if (hdr_cnt != 0 || got_q.size() != 0) begin
        report_error("response seen for a command without read data");
      end
      if (!is_rd && code == 8'd0 && cmd != 8'd47) begin
        for (int i = 0; i < len; i++) begin
          b = words[i / 4][8 * (i % 4) +: 8];
          case (cmd)
            8'd37: dev_reset_m[i] = b;
            8'd38: rec_ctrl_m[i] = b;
            default: begin
              if (i == 0) begin
                fifo_cms_m = b;
              end else if (b == FifoResetCode) begin
                fifo_q.delete();
                wr_m = 0;
                rd_m = 0;
              end
            end
          endcase
        end
      end
      proto_m = code;
    end
  endtask

  // One pop through the side read port, answer checked a cycle later
  task automatic read_fifo();
    bit          exp_valid;
    logic [31:0] exp_data;
    exp_valid  = fifo_q.size() > 0;
    exp_data   = exp_valid ? fifo_q[0] : '0;
    ifd_rreq_i = 1'b1;
    tick();
    ifd_rreq_i = 1'b0;
    @(negedge clk_i);
    if (ifd_rvalid_o !== exp_valid) report_mismatch("ifd_rvalid_o", 32'(ifd_rvalid_o), 32'(exp_valid));
    if (exp_valid && ifd_rdata_o !== exp_data) report_mismatch("ifd_rdata_o", ifd_rdata_o, exp_data);
    if (exp_valid) begin
      void'(fifo_q.pop_front());
      rd_m = (rd_m + 1) % FifoDepth;
    end
    tick();
  endtask

  task automatic check_payload(input logic exp);
    if (payload_available_o !== exp) begin
      report_mismatch("payload_available_o", 32'(payload_available_o), 32'(exp));
    end
  endtask

  initial begin
    int          nw;
    int          k;
    int          len;
    int          free;
    logic [7:0]  cmd;
    logic [31:0] w;
    rng = 32'd35;
    err_cnt = 0;
    errs_at_test = 0;
    tests_run = 0;
    tests_failed = 0;
    wr_m = 0;
    rd_m = 0;
    fifo_cms_m = '0;
    proto_m = '0;
    for (int i = 0; i < 3; i++) begin
      dev_reset_m[i] = '0;
      rec_ctrl_m[i]  = '0;
    end
    rst_ni = 1'b0;
    recovery_mode_i = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    rx_valid_i = 1'b0;
    rx_data_i = '0;
    res_ready_i = 1'b0;
    res_dready_i = 1'b0;
    ifd_rreq_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    @(negedge clk_i);
    if (cmd_ready_o !== 1'b1) report_mismatch("cmd_ready_o", 32'(cmd_ready_o), 32'd1);
    w = 32'({cmd_done_o, res_valid_o, res_dvalid_o, rx_ready_o, rx_clr_o, ifd_rvalid_o,
             payload_available_o});
    if (w !== 32'd0) report_mismatch("done/valid/dvalid/rx_ready/rx_clr/rvalid/payload", w, 0);
    tick();
    finish_test("reset values");

    for (int n = 0; n < NumProtCap; n++) run_cmd(CMD_PROT_CAP, 0, 1'b1, 1'b0);
    finish_test("PROT_CAP read");

    for (int n = 0; n < NumCsrWrites; n++) begin
      k = int'(rand32() % 3);
      w = rand32();
      if (k == 0) begin
        cmd = CMD_DEVICE_RESET;
        len = 1 + int'(rand32() % 3);
      end else if (k == 1) begin
        cmd = CMD_RECOVERY_CTRL;
        len = 1 + int'(rand32() % 3);
      end else begin
        cmd = CMD_INDIRECT_FIFO_CTRL;
        len = 1 + int'(rand32() % 2);
        w[15:8] = 8'd0;
      end
      rx_q.push_back(w);
      run_cmd(cmd, len, 1'b0, 1'b0);
      run_cmd(cmd, 0, 1'b1, 1'b0);
    end
    finish_test("CSR write and read back");

    for (int e = 0; e < NumErrCases; e++) begin
      case (e)
        0: begin
          rx_q.push_back(rand32());
          run_cmd(CMD_DEVICE_RESET, 3, 1'b0, 1'b1);
        end
        1: begin
          cmd = 8'(rand32());
          while (csr_length(cmd) != 0) cmd = 8'(rand32());
          run_cmd(cmd, 0, 1'b1, 1'b0);
        end
        2: begin
          recovery_mode_i = 1'b0;
          run_cmd(CMD_INDIRECT_FIFO_STATUS, 0, 1'b1, 1'b0);
          recovery_mode_i = 1'b1;
        end
        3: begin
          rx_q.push_back(rand32());
          run_cmd(CMD_DEVICE_STATUS, 4, 1'b0, 1'b0);
        end
        4: begin
          len = 4 + int'(rand32() % 5);
          for (int j = 0; j < (len + 3) / 4; j++) rx_q.push_back(rand32());
          run_cmd(CMD_DEVICE_RESET, len, 1'b0, 1'b0);
        end
        default: run_cmd(CMD_INDIRECT_FIFO_DATA, 4, 1'b1, 1'b0);
      endcase
      run_cmd(CMD_DEVICE_STATUS, 0, 1'b1, 1'b0);
      run_cmd(CMD_DEVICE_RESET, 0, 1'b1, 1'b0);
    end
    finish_test("protocol errors");

    for (int r = 0; r < NumFifoRounds; r++) begin
      free = FifoDepth - fifo_q.size();
      nw = 1 + int'(rand32() % 5);
      if (nw > free) nw = free;
      if (nw > 0) begin
        for (int j = 0; j < nw; j++) rx_q.push_back(rand32());
        len = 4 * nw - int'(rand32() % 4);
        run_cmd(CMD_INDIRECT_FIFO_DATA, len, 1'b0, 1'b0);
      end
      k = 1 + int'(rand32() % fifo_q.size());
      repeat (k) read_fifo();
      run_cmd(CMD_INDIRECT_FIFO_STATUS, 0, 1'b1, 1'b0);
    end
    while (fifo_q.size() > 0) read_fifo();
    read_fifo();
    run_cmd(CMD_INDIRECT_FIFO_STATUS, 0, 1'b1, 1'b0);
    finish_test("indirect FIFO data");

    rx_q.push_back(32'd0);
    run_cmd(CMD_RECOVERY_CTRL, 3, 1'b0, 1'b0);
    check_payload(1'b0);
    for (int j = 0; j < FifoDepth; j++) rx_q.push_back(rand32());
    run_cmd(CMD_INDIRECT_FIFO_DATA, 4 * FifoDepth, 1'b0, 1'b0);
    tick();
    check_payload(1'b1);
    // Pending word must wait while the FIFO is full
    rx_q.push_back(rand32());
    send_cmd(CMD_INDIRECT_FIFO_DATA, 4, 1'b0, 1'b0);
    repeat (6) begin
      rx_valid_i = 1'b1;
      rx_data_i  = rx_q[0];
      @(negedge clk_i);
      if (rx_ready_o !== 1'b0) report_mismatch("rx_ready_o", 32'(rx_ready_o), 32'd0);
      tick();
    end
    rx_valid_i = 1'b0;
    read_fifo();
    wait_cmd(1'b1);
    proto_m = ERR_OK;
    while (fifo_q.size() > 0) read_fifo();
    tick();
    check_payload(1'b0);
    rx_q.push_back({8'h00, ImageActivateCode, 16'(rand32())});
    run_cmd(CMD_RECOVERY_CTRL, 3, 1'b0, 1'b0);
    rx_q.push_back(rand32());
    run_cmd(CMD_INDIRECT_FIFO_DATA, 4, 1'b0, 1'b0);
    tick();
    check_payload(1'b1);
    read_fifo();
    tick();
    check_payload(1'b0);
    finish_test("full FIFO and payload flag");

    rx_q.push_back(rand32());
    rx_q.push_back(rand32());
    run_cmd(CMD_INDIRECT_FIFO_DATA, 8, 1'b0, 1'b0);
    read_fifo();
    rx_q.push_back({16'h0000, FifoResetCode, 8'(rand32())});
    run_cmd(CMD_INDIRECT_FIFO_CTRL, 2, 1'b0, 1'b0);
    run_cmd(CMD_INDIRECT_FIFO_STATUS, 0, 1'b1, 1'b0);
    run_cmd(CMD_INDIRECT_FIFO_CTRL, 0, 1'b1, 1'b0);
    read_fifo();
    finish_test("FIFO pointer reset");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
logic/recovery_pkg.sv
logic/recovery_cmd_fsm.sv
logic/recovery_csr_bank.sv
logic/recovery_indirect_fifo.sv
logic/recovery_executor.sv
dv/recovery_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module recovery_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vrecovery_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir
